// ==== src.f ====
+incdir+include
src/hp_abort_pkg.sv
src/hp_pending_if.sv
src/aw_len_fifo.sv
src/hp_pending_tracker.sv
src/hp_drain_engine.sv
src/hp_abort_csr.sv
src/hp_abort_top.sv
sim/hp_port_model.sv
sim/tb_hp_abort.sv

// ==== sim/tb_hp_abort.sv ====
`include "hp_abort_cfg.svh"

module tb_hp_abort
    import hp_abort_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DONE_LIMIT = 2000;

    typedef struct {
        string       name;
        int          nw;
        logic [15:0] wlens;             // burst lengths, one nibble each, burst 0 lowest
        int          nr;
        logic [15:0] rlens;
        int          w_pre;             // beats the master finishes before the abort
        int          r_pre;
        bit          fill_zero;
        bit          exp_mm;
    } row_t;

    row_t rows [6];

    logic                      hclk = 1'b0;
    logic                      reset_counters = 1'b1;
    logic                      reg_wr = 1'b0;
    logic                      reg_rd = 1'b0;
    logic [`REG_ADDR_W-1:0]    reg_addr = '0;
    logic [`REG_DATA_W-1:0]    reg_wdata = '0;
    logic [`REG_DATA_W-1:0]    reg_rdata;
    logic                      afi_awvalid = 1'b0;
    logic                      afi_awready = 1'b1;
    logic [`HP_ID_W-1:0]       afi_awid = '0;
    logic [`HP_LEN_W-1:0]      afi_awlen = '0;
    logic                      afi_wvalid_in = 1'b0;
    logic                      afi_wready;
    logic                      afi_arvalid = 1'b0;
    logic                      afi_arready = 1'b1;
    logic [`HP_LEN_W-1:0]      afi_arlen = '0;
    logic                      afi_rvalid;
    logic                      afi_rready_in = 1'b0;
    logic [`HP_RACOUNT_W-1:0]  afi_racount = '0;
    logic [`HP_RCOUNT_W-1:0]   afi_rcount = '0;
    logic [`HP_WACOUNT_W-1:0]  afi_wacount = '0;
    logic [`HP_WCOUNT_W-1:0]   afi_wcount = '0;
    logic                      afi_wvalid;
    logic [`HP_ID_W-1:0]       afi_wid;
    logic                      afi_wlast;
    logic                      afi_rready;
    logic                      busy;
    logic                      done;
    logic                      log_clr = 1'b0;

    hp_abort_top i_hp_abort_top (.*);
    hp_port_model port_model (.*);

    initial begin
        forever #20 hclk = ~hclk;
    end

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s expected %0d actual %0d", what, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // one register cycle from a falling edge, read data valid on return
    task automatic reg_access(input logic wr, input csr_addr_e addr, input logic [15:0] data);
        reg_wr    = wr;
        reg_rd    = !wr;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge hclk);
        reg_wr = 1'b0;
        reg_rd = 1'b0;
    endtask

    initial begin
        row_t        r;
        int          n;
        int          owed_w;
        int          owed_r;
        int          fill_sel;
        logic [3:0]  len;
        rows[0] = '{"write_only", 2, 16'h0073, 0, 16'h0000, 0, 0, 1'b0, 1'b0};
        rows[1] = '{"read_only", 0, 16'h0000, 2, 16'h0041, 0, 0, 1'b0, 1'b0};
        rows[2] = '{"mixed_partial", 3, 16'h0502, 2, 16'h0023, 2, 3, 1'b0, 1'b0};
        rows[3] = '{"fill_mismatch", 1, 16'h000F, 1, 16'h0000, 0, 0, 1'b1, 1'b1};
        rows[4] = '{"empty_abort", 0, 16'h0000, 0, 16'h0000, 0, 0, 1'b1, 1'b0};
        rows[5] = '{"head_retired", 2, 16'h0031, 1, 16'h0007, 2, 2, 1'b0, 1'b0};
        fill_sel = 0;
        repeat (8) @(negedge hclk);
        reset_counters = 1'b0;
        for (int t = 0; t < 6; t++) begin
            r       = rows[t];
            owed_w  = 0;
            owed_r  = 0;
            log_clr = 1'b1;
            @(negedge hclk);
            log_clr = 1'b0;
            for (int b = 0; b < r.nw; b++) begin
                afi_awid    = 6'(t * 4 + b + 1);
                afi_awlen   = r.wlens[b*4 +: 4];
                afi_awvalid = 1'b1;
                owed_w     += int'(afi_awlen) + 1;
                @(negedge hclk);
            end
            afi_awvalid   = 1'b0;
            afi_wvalid_in = 1'b1;
            repeat (r.w_pre) @(negedge hclk);
            afi_wvalid_in = 1'b0;
            for (int b = 0; b < r.nr; b++) begin
                afi_arlen   = r.rlens[b*4 +: 4];
                afi_arvalid = 1'b1;
                owed_r     += int'(afi_arlen) + 1;
                @(negedge hclk);
            end
            afi_arvalid   = 1'b0;
            afi_rready_in = 1'b1;
            repeat (r.r_pre) @(negedge hclk);
            afi_rready_in = 1'b0;
            // one fill counter nonzero per row, each in turn
            afi_racount = (!r.fill_zero && fill_sel == 0) ? 3'd1 : 3'd0;
            afi_rcount  = (!r.fill_zero && fill_sel == 1) ? 8'd4 : 8'd0;
            afi_wacount = (!r.fill_zero && fill_sel == 2) ? 6'd2 : 6'd0;
            afi_wcount  = (!r.fill_zero && fill_sel == 3) ? 8'd5 : 8'd0;
            if (!r.fill_zero)
                fill_sel = (fill_sel + 1) % 4;
            repeat (2) @(negedge hclk);         // let dirty settle
            reg_access(1'b0, reg_wbeats, 16'h0000);
            check_value({r.name, " wbeats before abort"}, owed_w - r.w_pre, reg_rdata);
            reg_access(1'b0, reg_rbeats, 16'h0000);
            check_value({r.name, " rbeats before abort"}, owed_r - r.r_pre, reg_rdata);
            reg_access(1'b1, reg_ctrl, 16'h0001);
            @(negedge hclk);                    // busy rises one edge after the abort
            check_value({r.name, " busy"}, 1, busy);
            n = 0;
            while (!done) begin
                if (n == DONE_LIMIT) begin
                    $display("timeout waiting for done after abort in row %s", r.name);
                    $display("tests failed");
                    $fatal(1);
                end else begin
                    @(negedge hclk);
                    n++;
                end
            end
            check_value({r.name, " busy at done"}, 0, busy);
            @(negedge hclk);                    // done-seen lands one edge after done
            check_value({r.name, " done pulse"}, 0, done);
            check_value({r.name, " w beats"}, owed_w - r.w_pre, port_model.w_cnt);
            check_value({r.name, " w hold"}, 0, port_model.hold_errs);
            n = 0;
            for (int b = 0; b < r.nw; b++) begin
                len = r.wlens[b*4 +: 4];
                for (int i = 0; i <= int'(len); i++) begin
                    if (n >= r.w_pre) begin
                        check_value({r.name, " wid"}, t * 4 + b + 1,
                                    port_model.w_log[n-r.w_pre][5:0]);
                        check_value({r.name, " wlast"}, int'(i == int'(len)),
                                    port_model.w_log[n-r.w_pre][6]);
                    end
                    n++;
                end
            end
            check_value({r.name, " r beats"}, owed_r - r.r_pre, port_model.r_cnt);
            reg_access(1'b0, reg_status, 16'h0000);
            check_value({r.name, " status"}, {r.exp_mm, 3'b010}, reg_rdata[3:0]);
            reg_access(1'b0, reg_wbeats, 16'h0000);
            check_value({r.name, " wbeats reg"}, 0, reg_rdata);
            reg_access(1'b0, reg_rbeats, 16'h0000);
            check_value({r.name, " rbeats reg"}, 0, reg_rdata);
            reg_access(1'b1, reg_ctrl, 16'h0002);   // clear mismatch
            reg_access(1'b0, reg_status, 16'h0000);
            check_value({r.name, " mismatch clear"}, 0, reg_rdata[3]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== sim/hp_port_model.sv ====
`include "hp_abort_cfg.svh"

module hp_port_model (
    input  logic                hclk,
    input  logic                log_clr,
    input  logic                busy,
    input  logic                afi_wvalid,
    input  logic [`HP_ID_W-1:0] afi_wid,
    input  logic                afi_wlast,
    input  logic                afi_rready,
    output logic                afi_wready,
    output logic                afi_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`HP_ID_W:0]   w_log [256];       // {wlast, wid} per drain beat
    int                  w_cnt;
    int                  r_cnt;
    int                  hold_errs;
    logic                stalled;
    logic [`HP_ID_W+1:0] held;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // port always ready outside a drain, random handshakes inside
    initial begin
        logic [15:0] lfsr;
        lfsr       = 16'd2;
        afi_wready = 1'b1;
        afi_rvalid = 1'b1;
        forever begin
            @(negedge hclk);
            afi_wready = busy ? lfsr[0] : 1'b1;
            lfsr       = busy ? lfsr_step(lfsr) : lfsr;
            afi_rvalid = busy ? lfsr[0] : 1'b1;
            lfsr       = busy ? lfsr_step(lfsr) : lfsr;
        end
    end

    always @(posedge hclk) begin
        if (log_clr) begin
            w_cnt     <= 0;
            r_cnt     <= 0;
            hold_errs <= 0;
            stalled   <= 1'b0;
        end else begin
            if (stalled && ({afi_wvalid, afi_wlast, afi_wid} != held))
                hold_errs <= hold_errs + 1;     // stalled beat changed
            stalled <= afi_wvalid && !afi_wready;
            held    <= {afi_wvalid, afi_wlast, afi_wid};
            if (afi_wvalid && afi_wready) begin
                w_log[w_cnt] <= {afi_wlast, afi_wid};
                w_cnt        <= w_cnt + 1;
            end
            if (afi_rvalid && afi_rready)
                r_cnt <= r_cnt + 1;
        end
    end

endmodule

// ==== src/hp_abort_top.sv ====
`include "hp_abort_cfg.svh"

module hp_abort_top (
    input  logic                      hclk,
    input  logic                      reset_counters,
    // register port
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  logic [`REG_ADDR_W-1:0]    reg_addr,
    input  logic [`REG_DATA_W-1:0]    reg_wdata,
    output logic [`REG_DATA_W-1:0]    reg_rdata,
    // master side of the HP port, observed
    input  logic                      afi_awvalid,
    input  logic                      afi_awready,
    input  logic [`HP_ID_W-1:0]       afi_awid,
    input  logic [`HP_LEN_W-1:0]      afi_awlen,
    input  logic                      afi_wvalid_in,
    input  logic                      afi_wready,
    input  logic                      afi_arvalid,
    input  logic                      afi_arready,
    input  logic [`HP_LEN_W-1:0]      afi_arlen,
    input  logic                      afi_rvalid,
    input  logic                      afi_rready_in,
    // port fill levels
    input  logic [`HP_RACOUNT_W-1:0]  afi_racount,
    input  logic [`HP_RCOUNT_W-1:0]   afi_rcount,
    input  logic [`HP_WACOUNT_W-1:0]  afi_wacount,
    input  logic [`HP_WCOUNT_W-1:0]   afi_wcount,
    // drain side
    output logic                      afi_wvalid,
    output logic [`HP_ID_W-1:0]       afi_wid,
    output logic                      afi_wlast,
    output logic                      afi_rready,
    output logic                      busy,
    output logic                      done
);
    logic w_fire;
    logic r_fire;
    logic port_fill_zero;
    logic abort_req;

    hp_pending_if pend_if ();

    // master and drain beats both retire owed traffic
    assign w_fire = (afi_wvalid_in || afi_wvalid) && afi_wready;
    assign r_fire = afi_rvalid && (afi_rready_in || afi_rready);

    assign port_fill_zero = (afi_racount == '0) && (afi_rcount == '0) &&
                            (afi_wacount == '0) && (afi_wcount == '0);

    hp_pending_tracker i_tracker (
        .hclk           (hclk),
        .reset_counters (reset_counters),
        .afi_awvalid    (afi_awvalid),
        .afi_awready    (afi_awready),
        .afi_awid       (afi_awid),
        .afi_awlen      (afi_awlen),
        .w_fire         (w_fire),
        .afi_arvalid    (afi_arvalid),
        .afi_arready    (afi_arready),
        .afi_arlen      (afi_arlen),
        .r_fire         (r_fire),
        .pend           (pend_if.tracker)
    );

    hp_drain_engine i_engine (
        .hclk           (hclk),
        .reset_counters (reset_counters),
        .abort_req      (abort_req),
        .pend           (pend_if.drain),
        .afi_wready     (afi_wready),
        .afi_wvalid     (afi_wvalid),
        .afi_wid        (afi_wid),
        .afi_wlast      (afi_wlast),
        .afi_rready     (afi_rready),
        .busy           (busy),
        .done           (done)
    );

    hp_abort_csr i_csr (
        .hclk           (hclk),
        .reset_counters (reset_counters),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .port_fill_zero (port_fill_zero),
        .busy           (busy),
        .done           (done),
        .pend           (pend_if.drain),    // reads counters and dirty only
        .abort_req      (abort_req)
    );

endmodule

// ==== src/hp_abort_csr.sv ====
`include "hp_abort_cfg.svh"

module hp_abort_csr
    import hp_abort_pkg::*;
(
    input  logic                    hclk,
    input  logic                    reset_counters,
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  logic [`REG_ADDR_W-1:0]  reg_addr,
    input  logic [`REG_DATA_W-1:0]  reg_wdata,
    output logic [`REG_DATA_W-1:0]  reg_rdata,
    input  logic                    port_fill_zero,
    input  logic                    busy,
    input  logic                    done,
    hp_pending_if.drain             pend,
    output logic                    abort_req
);
    logic ctrl_wr;
    logic clr_mismatch;
    logic mismatch;
    logic done_seen;

    assign ctrl_wr      = reg_wr && (reg_addr == reg_ctrl);
    assign abort_req    = ctrl_wr && reg_wdata[`CTRL_ABORT_BIT];
    assign clr_mismatch = ctrl_wr && reg_wdata[`CTRL_CLR_MM_BIT];

    always_ff @(posedge hclk) begin
        if (reset_counters) begin
            mismatch  <= 1'b0;
            done_seen <= 1'b0;
        end else begin
            if (clr_mismatch)
                mismatch <= 1'b0;
            // port FIFOs empty but tracker still sees traffic
            if (abort_req && port_fill_zero && pend.dirty)
                mismatch <= 1'b1;
            if (abort_req)
                done_seen <= 1'b0;
            else if (done)
                done_seen <= 1'b1;
        end
    end

    always_ff @(posedge hclk) begin
        if (reg_rd) begin
            case (csr_addr_e'(reg_addr))
                reg_ctrl:   reg_rdata <= '0;            // command bits self clear
                reg_status: reg_rdata <= {{(`REG_DATA_W-4){1'b0}},
                                          mismatch, pend.dirty, done_seen, busy};
                reg_wbeats: reg_rdata <= {{(`REG_DATA_W-`PEND_CNT_W){1'b0}}, pend.write_owed};
                reg_rbeats: reg_rdata <= {{(`REG_DATA_W-`PEND_CNT_W){1'b0}}, pend.read_owed};
                default:    reg_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== src/hp_drain_engine.sv ====
`include "hp_abort_cfg.svh"

module hp_drain_engine
    import hp_abort_pkg::*;
(
    input  logic                 hclk,
    input  logic                 reset_counters,
    input  logic                 abort_req,
    hp_pending_if.drain          pend,
    input  logic                 afi_wready,
    output logic                 afi_wvalid,
    output logic [`HP_ID_W-1:0]  afi_wid,
    output logic                 afi_wlast,
    output logic                 afi_rready,
    output logic                 busy,
    output logic                 done
);
    drain_state_e state;
    logic         draining;
    logic         all_clear;

    assign draining  = (state == st_draining);
    assign all_clear = (pend.write_owed == '0) && (pend.read_owed == '0) && !pend.head_valid;

    // dummy W beats, zero data, ID and WLAST from the queue head
    assign afi_wvalid = draining && (pend.write_owed != '0) && pend.head_valid;
    assign afi_wid    = pend.head_id;
    assign afi_wlast  = afi_wvalid && (pend.head_len == '0);

    // accept whatever read beats are still owed
    assign afi_rready = draining && (pend.read_owed != '0);

    assign pend.burst_pop = afi_wvalid && afi_wready && afi_wlast;

    always_ff @(posedge hclk) begin
        if (reset_counters) begin
            state <= st_idle;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (abort_req)
                        state <= pend.dirty ? st_draining : st_finish;
                end
                st_draining: begin
                    busy <= 1'b1;
                    if (all_clear)
                        state <= st_finish;
                end
                st_finish: begin
                    // done and busy fall together, busy is up at least one cycle
                    if (busy) begin
                        state <= st_idle;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else begin
                        busy <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== src/hp_pending_tracker.sv ====
`include "hp_abort_cfg.svh"

module hp_pending_tracker (
    input  logic                  hclk,
    input  logic                  reset_counters,
    input  logic                  afi_awvalid,
    input  logic                  afi_awready,
    input  logic [`HP_ID_W-1:0]   afi_awid,
    input  logic [`HP_LEN_W-1:0]  afi_awlen,
    input  logic                  w_fire,
    input  logic                  afi_arvalid,
    input  logic                  afi_arready,
    input  logic [`HP_LEN_W-1:0]  afi_arlen,
    input  logic                  r_fire,
    hp_pending_if.tracker         pend
);
    logic                         aw_fire;
    logic                         ar_fire;
    logic                         aw_push;
    logic                         q_pop;
    logic                         q_full;
    logic [`HP_LEN_W-1:0]         q_len;
    logic [`HP_ID_W-1:0]          q_id;
    logic [`AW_Q_DEPTH_LOG2:0]    q_count;
    logic [`HP_LEN_W-1:0]         head_done;    // beats already taken from head burst
    logic [`HP_LEN_W-1:0]         head_rem;
    logic                         head_beat;
    logic [`PEND_CNT_W-1:0]       write_owed;
    logic [`PEND_CNT_W-1:0]       read_owed;

    // owed += len+1 on a burst, -= 1 on a beat, both may hit in one cycle
    function automatic logic [`PEND_CNT_W-1:0] owed_next(
        input logic [`PEND_CNT_W-1:0] cur,
        input logic                   add_en,
        input logic [`HP_LEN_W-1:0]   len,
        input logic                   sub_en
    );
        logic [`PEND_CNT_W-1:0] add;
        logic [`PEND_CNT_W-1:0] sub;
        add = add_en ? {{(`PEND_CNT_W-`HP_LEN_W){1'b0}}, len} + 1'b1 : '0;
        sub = (sub_en && (cur != '0)) ? `PEND_CNT_W'(1) : '0;
        return cur + add - sub;
    endfunction

    assign aw_fire   = afi_awvalid && afi_awready;
    assign ar_fire   = afi_arvalid && afi_arready;
    assign aw_push   = aw_fire && !q_full;          // burst dropped if queue overflows
    assign head_beat = w_fire && (q_count != '0);
    assign head_rem  = q_len - head_done;
    // engine pop, or master finishing the head burst on its own
    assign q_pop     = pend.burst_pop || (head_beat && (head_rem == '0));

    aw_len_fifo i_aw_len_fifo (
        .hclk           (hclk),
        .reset_counters (reset_counters),
        .push           (aw_push),
        .push_len       (afi_awlen),
        .push_id        (afi_awid),
        .pop            (q_pop),
        .head_len       (q_len),
        .head_id        (q_id),
        .count          (q_count),
        .full           (q_full)
    );

    always_ff @(posedge hclk) begin
        if (reset_counters) begin
            head_done  <= '0;
            write_owed <= '0;
            read_owed  <= '0;
            pend.dirty <= 1'b0;
        end else begin
            if (q_pop)
                head_done <= '0;
            else if (head_beat)
                head_done <= head_done + 1'b1;
            write_owed <= owed_next(write_owed, aw_push, afi_awlen, w_fire);
            read_owed  <= owed_next(read_owed, ar_fire, afi_arlen, r_fire);
            pend.dirty <= (write_owed != '0) || (read_owed != '0) || (q_count != '0);
        end
    end

    assign pend.head_len   = head_rem;
    assign pend.head_id    = q_id;
    assign pend.head_valid = (q_count != '0);
    assign pend.write_owed = write_owed;
    assign pend.read_owed  = read_owed;

endmodule

// ==== src/aw_len_fifo.sv ====
`include "hp_abort_cfg.svh"

module aw_len_fifo (
    input  logic                         hclk,
    input  logic                         reset_counters,
    input  logic                         push,
    input  logic [`HP_LEN_W-1:0]         push_len,
    input  logic [`HP_ID_W-1:0]          push_id,
    input  logic                         pop,
    output logic [`HP_LEN_W-1:0]         head_len,
    output logic [`HP_ID_W-1:0]          head_id,
    output logic [`AW_Q_DEPTH_LOG2:0]    count,
    output logic                         full
);
    localparam int DEPTH = 1 << `AW_Q_DEPTH_LOG2;

    logic [`HP_LEN_W-1:0]          len_mem [DEPTH];
    logic [`HP_ID_W-1:0]           id_mem  [DEPTH];
    logic [`AW_Q_DEPTH_LOG2-1:0]   wr_ptr;
    logic [`AW_Q_DEPTH_LOG2-1:0]   rd_ptr;
    logic                          do_push;
    logic                          do_pop;

    assign full     = (count == DEPTH[`AW_Q_DEPTH_LOG2:0]);
    assign do_push  = push && !full;
    assign do_pop   = pop && (count != '0);     // pop on empty is dropped
    assign head_len = len_mem[rd_ptr];
    assign head_id  = id_mem[rd_ptr];

    always_ff @(posedge hclk) begin
        if (do_push) begin
            len_mem[wr_ptr] <= push_len;
            id_mem[wr_ptr]  <= push_id;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset_counters) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

// ==== src/hp_pending_if.sv ====
`include "hp_abort_cfg.svh"

interface hp_pending_if;

    // head of the burst queue
    // head_len is the index of the burst's last beat, counted from the next beat owed
    logic [`HP_LEN_W-1:0]   head_len;
    logic [`HP_ID_W-1:0]    head_id;
    logic                   head_valid;     // queue not empty
    logic                   burst_pop;      // engine finished the head burst

    logic [`PEND_CNT_W-1:0] write_owed;
    logic [`PEND_CNT_W-1:0] read_owed;
    logic                   dirty;          // anything outstanding, registered

    modport tracker (
        output head_len,
        output head_id,
        output head_valid,
        output write_owed,
        output read_owed,
        output dirty,
        input  burst_pop
    );

    modport drain (
        input  head_len,
        input  head_id,
        input  head_valid,
        input  write_owed,
        input  read_owed,
        input  dirty,
        output burst_pop
    );

endinterface

// ==== src/hp_abort_pkg.sv ====
`include "hp_abort_cfg.svh"

package hp_abort_pkg;

    // drain FSM
    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_draining = 2'd1,             // W beats and R acceptance active
        st_finish   = 2'd2              // waits for busy, then pulses done
    } drain_state_e;

    // register map
    typedef enum logic [`REG_ADDR_W-1:0] {
        reg_ctrl   = 'd0,
        reg_status = 'd1,
        reg_wbeats = 'd2,
        reg_rbeats = 'd3
    } csr_addr_e;

endpackage

// ==== include/hp_abort_cfg.svh ====
`ifndef HP_ABORT_CFG_SVH
`define HP_ABORT_CFG_SVH

// AXI3 HP port fields
`define HP_ID_W          6
`define HP_LEN_W         4

// port fill counters, only sampled at abort
`define HP_RACOUNT_W     3
`define HP_RCOUNT_W      8
`define HP_WACOUNT_W     6
`define HP_WCOUNT_W      8

`define AW_Q_DEPTH_LOG2  5              // 32 bursts in flight
`define PEND_CNT_W       9              // owed beat counters

// register port
`define REG_DATA_W       16
`define REG_ADDR_W       2

`define CTRL_ABORT_BIT   0              // write 1 starts a drain
`define CTRL_CLR_MM_BIT  1              // write 1 clears mismatch

`endif
